/* dbg_mon_config.svh */
`ifndef DBG_MON_CONFIG_SVH
`define DBG_MON_CONFIG_SVH

// Widths
`define DBG_XLEN        32
`define DBG_COUNT_W     16
`define DBG_AXIL_ADDR_W 5

// Full instruction words, matched exactly
`define DBG_ENC_EBREAK  32'h0010_0073
`define DBG_ENC_CEBREAK 32'h0000_9002
`define DBG_ENC_WFI     32'h1050_0073

// dcsr.cause codes
`define DBG_CAUSE_NONE    3'd0
`define DBG_CAUSE_EBREAK  3'd1
`define DBG_CAUSE_TRIGGER 3'd2
`define DBG_CAUSE_HALTREQ 3'd3
`define DBG_CAUSE_STEP    3'd4

// Register byte offsets
`define DBG_REG_CTRL      5'h00
`define DBG_REG_STATUS    5'h04
`define DBG_REG_ENTRIES   5'h08
`define DBG_REG_CAUSE_ERR 5'h0c
`define DBG_REG_PC_ERR    5'h10
`define DBG_REG_PC_EBREAK 5'h14
`define DBG_REG_PC_DBG    5'h18

// AXI4-Lite response codes
`define DBG_RESP_OKAY   2'b00
`define DBG_RESP_SLVERR 2'b10

`endif

/* dbg_isa_pkg.sv */
`default_nettype none
`include "dbg_mon_config.svh"

package dbg_isa_pkg;

  typedef logic [`DBG_XLEN-1:0] word_t;
  typedef logic [`DBG_XLEN-1:0] addr_t;
  typedef logic [2:0]           cause_t;

  // One entry of the retirement trace
  typedef struct packed {
    logic  valid;
    logic  err;
    addr_t pc;
    addr_t next_pc;
    word_t instr;
  } retire_t;

  // Debug related state of the core
  typedef struct packed {
    logic   debug_mode;
    cause_t dcsr_cause;
    logic   step;
    logic   ebreakm;
    logic   debug_req;
    logic   trig_en;
    addr_t  tdata2;
    addr_t  depc;
    logic   irq_pending;
  } core_status_t;

  // Registered decode result
  typedef struct packed {
    logic         valid;
    addr_t        pc;
    addr_t        next_pc;
    logic         is_ebreak_any;
    logic         is_wfi;
    logic         is_trigger;
    core_status_t core;
  } dec_instr_t;

endpackage

`default_nettype wire

/* dbg_mon_pkg.sv */
`default_nettype none
`include "dbg_mon_config.svh"

package dbg_mon_pkg;

  typedef logic [`DBG_COUNT_W-1:0]     count_t;
  typedef logic [`DBG_AXIL_ADDR_W-1:0] reg_addr_t;

  // ----------------------------------------
  // AXI4-Lite slave side
  // ----------------------------------------
  typedef struct packed {
    reg_addr_t                 awaddr;
    logic                      awvalid;
    dbg_isa_pkg::word_t        wdata;
    logic [`DBG_XLEN/8-1:0]    wstrb;
    logic                      wvalid;
    logic                      bready;
    reg_addr_t                 araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_req_t;

  typedef struct packed {
    logic               awready;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               arready;
    dbg_isa_pkg::word_t rdata;
    logic [1:0]         rresp;
    logic               rvalid;
  } axil_rsp_t;

  // Expected sleep state of the core
  typedef enum logic {
    WFI_RUN,
    WFI_SLEEP
  } wfi_state_e;

  // One debug-mode entry as seen by the monitor
  typedef struct packed {
    logic                valid;
    logic                cause_ok;
    dbg_isa_pkg::cause_t cause;
  } entry_evt_t;

endpackage

`default_nettype wire

/* dbg_instr_decode.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dbg_mon_config.svh"

module dbg_instr_decode (
  input  wire                           cov_assert_if,
  input  wire                           rst_n_i,
  input  var dbg_isa_pkg::retire_t      retire_i,
  input  var dbg_isa_pkg::core_status_t core_i,
  output dbg_isa_pkg::dec_instr_t       dec_o
);

  logic ret_ok;
  logic ebreak_hit;
  logic wfi_hit;
  logic trig_hit;

  // A faulting retirement never counts as ebreak or wfi
  assign ret_ok = retire_i.valid && !retire_i.err;

  assign ebreak_hit = ret_ok &&
                      ((retire_i.instr == `DBG_ENC_EBREAK) ||
                       (retire_i.instr == `DBG_ENC_CEBREAK));

  assign wfi_hit = ret_ok && (retire_i.instr == `DBG_ENC_WFI);

  // Address trigger fires on the PC alone
  assign trig_hit = retire_i.valid && core_i.trig_en && (retire_i.pc == core_i.tdata2);

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_o <= '0;
    end else begin
      dec_o.valid         <= retire_i.valid;
      dec_o.pc            <= retire_i.pc;
      dec_o.next_pc       <= retire_i.next_pc;
      dec_o.is_ebreak_any <= ebreak_hit;
      dec_o.is_wfi        <= wfi_hit;
      dec_o.is_trigger    <= trig_hit;
      // Status travels with the record so both stay aligned
      dec_o.core          <= core_i;
    end
  end

endmodule

`default_nettype wire

/* dbg_cause_track.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dbg_mon_config.svh"

module dbg_cause_track (
  input  wire                         cov_assert_if,
  input  wire                         rst_n_i,
  input  var dbg_isa_pkg::dec_instr_t dec_i,
  input  wire                         monitor_en_i,
  output dbg_isa_pkg::cause_t         expected_cause_o,
  output dbg_mon_pkg::entry_evt_t     entry_o,
  output dbg_mon_pkg::wfi_state_e     wfi_state_o
);

  dbg_isa_pkg::cause_t     cause_n;
  logic                    cause_ld;
  logic                    dm_q;
  logic                    dm_rise;
  logic                    dm_fall;
  dbg_mon_pkg::wfi_state_e wfi_q;
  dbg_mon_pkg::wfi_state_e wfi_n;
  logic                    wfi_enter;
  logic                    wfi_wake;

  assign dm_rise = dec_i.core.debug_mode && !dm_q;
  assign dm_fall = !dec_i.core.debug_mode && dm_q;

  // ----------------------------------------
  // Expected cause
  // ----------------------------------------

  // Fixed priority: trigger, ebreak, haltreq, step
  always_comb begin
    cause_ld = 1'b1;
    if (dec_i.is_trigger) begin
      cause_n = `DBG_CAUSE_TRIGGER;
    end else if (dec_i.is_ebreak_any && dec_i.core.ebreakm) begin
      cause_n = `DBG_CAUSE_EBREAK;
    end else if (dec_i.core.debug_req) begin
      cause_n = `DBG_CAUSE_HALTREQ;
    end else if (dec_i.core.step && dec_i.valid) begin
      cause_n = `DBG_CAUSE_STEP;
    end else begin
      cause_n  = `DBG_CAUSE_NONE;
      cause_ld = 1'b0;
    end
  end

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      expected_cause_o <= `DBG_CAUSE_NONE;
      dm_q             <= 1'b0;
    end else begin
      dm_q <= dec_i.core.debug_mode;
      if (dm_fall) begin
        expected_cause_o <= `DBG_CAUSE_NONE;
      end else if (!dec_i.core.debug_mode && cause_ld) begin
        expected_cause_o <= cause_n;
      end
    end
  end

  // Entry event, compared against the cause held before entry
  always_comb begin
    entry_o.valid    = monitor_en_i && dm_rise;
    entry_o.cause_ok = (dec_i.core.dcsr_cause == expected_cause_o);
    entry_o.cause    = dec_i.core.dcsr_cause;
  end

  // ----------------------------------------
  // WFI sleep FSM
  // ----------------------------------------

  // No sleep in debug mode, with a pending halt, or while stepping
  assign wfi_enter = dec_i.is_wfi && !dec_i.core.debug_mode &&
                     !dec_i.core.debug_req && !dec_i.core.step;
  assign wfi_wake  = dec_i.core.irq_pending || dec_i.core.debug_req;

  always_comb begin
    wfi_n = wfi_q;
    case (wfi_q)
      dbg_mon_pkg::WFI_RUN: begin
        if (wfi_enter && !wfi_wake) begin
          wfi_n = dbg_mon_pkg::WFI_SLEEP;
        end
      end
      dbg_mon_pkg::WFI_SLEEP: begin
        if (wfi_wake) begin
          wfi_n = dbg_mon_pkg::WFI_RUN;
        end
      end
      default: wfi_n = dbg_mon_pkg::WFI_RUN;
    endcase
  end

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wfi_q <= dbg_mon_pkg::WFI_RUN;
    end else begin
      wfi_q <= wfi_n;
    end
  end

  assign wfi_state_o = wfi_q;

endmodule

`default_nettype wire

/* dbg_pc_capture.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dbg_mon_config.svh"

module dbg_pc_capture (
  input  wire                          cov_assert_if,
  input  wire                          rst_n_i,
  input  var dbg_isa_pkg::dec_instr_t  dec_i,
  input  var dbg_isa_pkg::cause_t      expected_cause_i,
  input  var dbg_mon_pkg::entry_evt_t  entry_i,
  output dbg_isa_pkg::addr_t           pc_dbg_o,
  output dbg_isa_pkg::addr_t           pc_ebreak_o,
  output logic                         pc_err_o
);

  logic bp_hit;
  logic dpc_check;

  // Trigger and ebreak save the PC of the instruction itself,
  // every other cause saves the PC that would retire next
  assign bp_hit = dec_i.is_trigger || (dec_i.is_ebreak_any && dec_i.core.ebreakm);

  // An entry with no expected cause has no reference PC
  assign dpc_check = entry_i.valid && (expected_cause_i != `DBG_CAUSE_NONE);

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_dbg_o    <= '0;
      pc_ebreak_o <= '0;
      pc_err_o    <= 1'b0;
    end else begin
      // Held while in debug mode so depc is checked against it
      if (dec_i.valid && !dec_i.core.debug_mode) begin
        pc_dbg_o <= bp_hit ? dec_i.pc : dec_i.next_pc;
      end

      // Any clean ebreak, with or without ebreakm
      if (dec_i.is_ebreak_any) begin
        pc_ebreak_o <= dec_i.pc;
      end

      pc_err_o <= dpc_check && (dec_i.core.depc != pc_dbg_o);
    end
  end

endmodule

`default_nettype wire

/* dbg_mon_regs.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dbg_mon_config.svh"

module dbg_mon_regs (
  input  wire                          cov_assert_if,
  input  wire                          rst_n_i,
  input  var dbg_mon_pkg::axil_req_t   axil_req_i,
  output dbg_mon_pkg::axil_rsp_t       axil_rsp_o,
  input  var dbg_mon_pkg::entry_evt_t  entry_i,
  input  wire                          pc_err_i,
  input  var dbg_isa_pkg::cause_t      expected_cause_i,
  input  var dbg_mon_pkg::wfi_state_e  wfi_state_i,
  input  var dbg_isa_pkg::addr_t       pc_dbg_i,
  input  var dbg_isa_pkg::addr_t       pc_ebreak_i,
  output logic                         monitor_en_o
);

  dbg_mon_pkg::count_t    entries_q;
  dbg_mon_pkg::count_t    cause_err_q;
  dbg_mon_pkg::count_t    pc_err_q;
  dbg_isa_pkg::cause_t    last_cause_q;
  logic                   ctrl_en_q;
  logic                   clr;
  logic                   rst_done_q;
  logic                   aw_done_q;
  logic                   w_done_q;
  dbg_mon_pkg::reg_addr_t awaddr_q;
  dbg_isa_pkg::word_t     wdata_q;
  logic                   wstrb0_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic                   wr_fire;
  logic                   wr_ok;
  dbg_mon_pkg::reg_addr_t wr_addr;
  dbg_isa_pkg::word_t     wr_data;
  logic                   wr_strb0;
  logic                   bvalid_q;
  logic [1:0]             bresp_q;
  logic                   ar_hs;
  logic                   rd_ok;
  dbg_isa_pkg::word_t     rd_data;
  logic                   rvalid_q;
  logic [1:0]             rresp_q;
  dbg_isa_pkg::word_t     rdata_q;

  function automatic dbg_mon_pkg::count_t sat_inc(dbg_mon_pkg::count_t cnt, logic inc);
    if (inc && (cnt != '1)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  // Readies stay low through reset and while a response is pending
  always_comb begin
    axil_rsp_o.awready = rst_done_q && !aw_done_q && !bvalid_q;
    axil_rsp_o.wready  = rst_done_q && !w_done_q && !bvalid_q;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = rst_done_q && !rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
    axil_rsp_o.rvalid  = rvalid_q;
  end

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  assign aw_hs    = axil_req_i.awvalid && axil_rsp_o.awready;
  assign w_hs     = axil_req_i.wvalid && axil_rsp_o.wready;
  assign wr_fire  = (aw_hs || aw_done_q) && (w_hs || w_done_q);
  assign wr_addr  = aw_done_q ? awaddr_q : axil_req_i.awaddr;
  assign wr_data  = w_done_q ? wdata_q : axil_req_i.wdata;
  assign wr_strb0 = w_done_q ? wstrb0_q : axil_req_i.wstrb[0];
  // Only CTRL is writable
  assign wr_ok    = (wr_addr == `DBG_REG_CTRL);
  assign clr      = wr_fire && wr_ok && wr_strb0 && wr_data[1];

  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_done_q <= 1'b0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
      bvalid_q   <= 1'b0;
      bresp_q    <= `DBG_RESP_OKAY;
      ctrl_en_q  <= 1'b1;
    end else begin
      rst_done_q <= 1'b1;
      if (wr_fire) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        bvalid_q  <= 1'b1;
        bresp_q   <= wr_ok ? `DBG_RESP_OKAY : `DBG_RESP_SLVERR;
        if (wr_ok && wr_strb0) begin
          ctrl_en_q <= wr_data[0];
        end
      end else begin
        if (aw_hs) begin
          aw_done_q <= 1'b1;
        end
        if (w_hs) begin
          w_done_q <= 1'b1;
        end
        if (bvalid_q && axil_req_i.bready) begin
          bvalid_q <= 1'b0;
        end
      end
    end
  end

  // AW and W may arrive apart
  always_ff @(posedge cov_assert_if) begin
    if (aw_hs) begin
      awaddr_q <= axil_req_i.awaddr;
    end
    if (w_hs) begin
      wdata_q  <= axil_req_i.wdata;
      wstrb0_q <= axil_req_i.wstrb[0];
    end
  end

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  assign ar_hs = axil_req_i.arvalid && axil_rsp_o.arready;

  always_comb begin
    rd_ok   = 1'b1;
    rd_data = '0;
    case (axil_req_i.araddr)
      `DBG_REG_CTRL:      rd_data = dbg_isa_pkg::word_t'(ctrl_en_q);
      `DBG_REG_STATUS:    rd_data = dbg_isa_pkg::word_t'({wfi_state_i == dbg_mon_pkg::WFI_SLEEP,
                                                          1'b0, last_cause_q,
                                                          1'b0, expected_cause_i});
      `DBG_REG_ENTRIES:   rd_data = dbg_isa_pkg::word_t'(entries_q);
      `DBG_REG_CAUSE_ERR: rd_data = dbg_isa_pkg::word_t'(cause_err_q);
      `DBG_REG_PC_ERR:    rd_data = dbg_isa_pkg::word_t'(pc_err_q);
      `DBG_REG_PC_EBREAK: rd_data = pc_ebreak_i;
      `DBG_REG_PC_DBG:    rd_data = pc_dbg_i;
      default:            rd_ok   = 1'b0;
    endcase
  end

  // Response is held until rready
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rresp_q  <= `DBG_RESP_OKAY;
      rdata_q  <= '0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
      rresp_q  <= rd_ok ? `DBG_RESP_OKAY : `DBG_RESP_SLVERR;
      rdata_q  <= rd_data;
    end else if (rvalid_q && axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // ----------------------------------------
  // Counters
  // ----------------------------------------
  always_ff @(posedge cov_assert_if or negedge rst_n_i) begin
    if (!rst_n_i) begin
      entries_q    <= '0;
      cause_err_q  <= '0;
      pc_err_q     <= '0;
      last_cause_q <= `DBG_CAUSE_NONE;
    end else begin
      if (entry_i.valid) begin
        last_cause_q <= entry_i.cause;
      end
      if (clr) begin
        entries_q   <= '0;
        cause_err_q <= '0;
        pc_err_q    <= '0;
      end else begin
        entries_q   <= sat_inc(entries_q, entry_i.valid);
        cause_err_q <= sat_inc(cause_err_q, entry_i.valid && !entry_i.cause_ok);
        pc_err_q    <= sat_inc(pc_err_q, pc_err_i);
      end
    end
  end

  assign monitor_en_o = ctrl_en_q;

endmodule

`default_nettype wire

/* dbg_event_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module dbg_event_monitor (
  input  wire                           cov_assert_if,
  input  wire                           rst_n_i,
  input  var dbg_isa_pkg::retire_t      retire_i,
  input  var dbg_isa_pkg::core_status_t core_i,
  input  var dbg_mon_pkg::axil_req_t    axil_req_i,
  output dbg_mon_pkg::axil_rsp_t        axil_rsp_o,
  output logic                          wfi_sleep_o
);

  dbg_isa_pkg::dec_instr_t dec;
  dbg_isa_pkg::cause_t     expected_cause;
  dbg_mon_pkg::entry_evt_t entry;
  dbg_mon_pkg::wfi_state_e wfi_state;
  dbg_isa_pkg::addr_t      pc_dbg;
  dbg_isa_pkg::addr_t      pc_ebreak;
  logic                    pc_err;
  logic                    monitor_en;

  // Decode stage
  dbg_instr_decode u_decode (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .retire_i      (retire_i),
    .core_i        (core_i),
    .dec_o         (dec)
  );

  // Execute stages
  dbg_cause_track u_cause (
    .cov_assert_if    (cov_assert_if),
    .rst_n_i          (rst_n_i),
    .dec_i            (dec),
    .monitor_en_i     (monitor_en),
    .expected_cause_o (expected_cause),
    .entry_o          (entry),
    .wfi_state_o      (wfi_state)
  );

  dbg_pc_capture u_pc (
    .cov_assert_if    (cov_assert_if),
    .rst_n_i          (rst_n_i),
    .dec_i            (dec),
    .expected_cause_i (expected_cause),
    .entry_i          (entry),
    .pc_dbg_o         (pc_dbg),
    .pc_ebreak_o      (pc_ebreak),
    .pc_err_o         (pc_err)
  );

  // Result stage and register file
  dbg_mon_regs u_regs (
    .cov_assert_if    (cov_assert_if),
    .rst_n_i          (rst_n_i),
    .axil_req_i       (axil_req_i),
    .axil_rsp_o       (axil_rsp_o),
    .entry_i          (entry),
    .pc_err_i         (pc_err),
    .expected_cause_i (expected_cause),
    .wfi_state_i      (wfi_state),
    .pc_dbg_i         (pc_dbg),
    .pc_ebreak_i      (pc_ebreak),
    .monitor_en_o     (monitor_en)
  );

  assign wfi_sleep_o = (wfi_state == dbg_mon_pkg::WFI_SLEEP);

endmodule

`default_nettype wire

/* tb_dbg_event_monitor_tasks.svh */
// ----------------------------------------
// Typed compares
// ----------------------------------------
task automatic check_word(input string name, input dbg_isa_pkg::word_t got,
                          input dbg_isa_pkg::word_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_count(input string name, input dbg_mon_pkg::count_t got,
                           input dbg_mon_pkg::count_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_cause(input string name, input dbg_isa_pkg::cause_t got,
                           input dbg_isa_pkg::cause_t exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
  end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
  end
endtask

// ----------------------------------------
// AXI4-Lite host
// ----------------------------------------
task automatic axil_read(input dbg_mon_pkg::reg_addr_t addr,
                         output dbg_isa_pkg::word_t data, output logic [1:0] resp);
  int stall;
  @(negedge cov_assert_if);
  axil_req.araddr  = addr;
  axil_req.arvalid = 1'b1;
  while (!axil_rsp.arready) begin
    @(negedge cov_assert_if);
  end
  @(negedge cov_assert_if);
  axil_req.arvalid = 1'b0;
  while (!axil_rsp.rvalid) begin
    @(negedge cov_assert_if);
  end
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  // Second request waits on AR while rready is held low
  axil_req.araddr  = `DBG_REG_PC_DBG;
  axil_req.arvalid = 1'b1;
  stall = 1 + ($urandom % 3);
  repeat (stall) begin
    @(negedge cov_assert_if);
    if (!axil_rsp.rvalid || axil_rsp.arready) begin
      errors++;
      $display("Read response dropped or second read accepted under back-pressure at %0t",
               $time);
    end
    check_word("rdata", axil_rsp.rdata, data);
    check_resp("rresp", axil_rsp.rresp, resp);
  end
  axil_req.rready = 1'b1;
  @(negedge cov_assert_if);
  axil_req.rready  = 1'b0;
  axil_req.arvalid = 1'b0;
  if (axil_rsp.rvalid) begin
    errors++;
    $display("Read response still valid after rready at %0t", $time);
  end
endtask

task automatic axil_write(input dbg_mon_pkg::reg_addr_t addr, input dbg_isa_pkg::word_t data,
                          output logic [1:0] resp);
  logic aw_go;
  logic w_go;
  int   stall;
  @(negedge cov_assert_if);
  axil_req.awaddr  = addr;
  axil_req.awvalid = 1'b1;
  axil_req.wdata   = data;
  axil_req.wstrb   = '1;
  axil_req.wvalid  = 1'b1;
  while (axil_req.awvalid || axil_req.wvalid) begin
    aw_go = axil_req.awvalid && axil_rsp.awready;
    w_go  = axil_req.wvalid && axil_rsp.wready;
    @(negedge cov_assert_if);
    if (aw_go) begin
      axil_req.awvalid = 1'b0;
    end
    if (w_go) begin
      axil_req.wvalid = 1'b0;
    end
  end
  while (!axil_rsp.bvalid) begin
    @(negedge cov_assert_if);
  end
  resp  = axil_rsp.bresp;
  stall = 1 + ($urandom % 3);
  repeat (stall) begin
    @(negedge cov_assert_if);
    if (!axil_rsp.bvalid || axil_rsp.awready || axil_rsp.wready) begin
      errors++;
      $display("Write response dropped or write channel ready under back-pressure at %0t",
               $time);
    end
    check_resp("bresp", axil_rsp.bresp, resp);
  end
  axil_req.bready = 1'b1;
  @(negedge cov_assert_if);
  axil_req.bready = 1'b0;
  if (axil_rsp.bvalid) begin
    errors++;
    $display("Write response still valid after bready at %0t", $time);
  end
endtask

// ----------------------------------------
// Core side
// ----------------------------------------
task automatic drive_row(input row_t r);
  @(negedge cov_assert_if);
  retire.valid     = 1'b1;
  retire.err       = r.flags.err;
  retire.pc        = r.pc;
  retire.next_pc   = r.next_pc;
  retire.instr     = r.instr;
  core             = '0;
  core.step        = r.flags.step;
  core.ebreakm     = r.flags.ebreakm;
  core.debug_req   = r.flags.debug_req;
  core.trig_en     = r.flags.trig_en;
  core.tdata2      = r.tdata2;
  core.irq_pending = r.flags.irq;
  core.dcsr_cause  = r.dcsr_cause;
  core.depc        = r.depc;
  // Idle cycle, status flags drop with the retirement
  @(negedge cov_assert_if);
  retire           = '0;
  core.step        = 1'b0;
  core.ebreakm     = 1'b0;
  core.debug_req   = 1'b0;
  core.trig_en     = 1'b0;
  core.irq_pending = 1'b0;
  if (r.mode.entry) begin
    @(negedge cov_assert_if);
    core.debug_mode = 1'b1;
    if (r.mode.dm_wfi) begin
      retire.valid   = 1'b1;
      retire.pc      = r.next_pc;
      retire.next_pc = r.next_pc + 32'd4;
      retire.instr   = WFI_I;
    end
    repeat (2) @(negedge cov_assert_if);
    core.debug_mode = 1'b0;
    retire          = '0;
    repeat (2) @(negedge cov_assert_if);
  end
  repeat (4) @(negedge cov_assert_if);
endtask

/* tb_dbg_event_monitor.sv */
`timescale 1ns/100ps
`default_nettype none
`include "dbg_mon_config.svh"

module tb_dbg_event_monitor;

  // Flag order matches the 6-bit literals in the table
  typedef struct packed {
    logic err;
    logic step;
    logic ebreakm;
    logic debug_req;
    logic trig_en;
    logic irq;
  } flags_t;

  typedef struct packed {
    logic entry;
    logic dm_wfi;
  } mode_t;

  typedef struct packed {
    dbg_isa_pkg::addr_t  pc;
    dbg_isa_pkg::addr_t  next_pc;
    dbg_isa_pkg::word_t  instr;
    flags_t              flags;
    dbg_isa_pkg::addr_t  tdata2;
    dbg_isa_pkg::cause_t dcsr_cause;
    dbg_isa_pkg::addr_t  depc;
    mode_t               mode;
  } row_t;

  localparam int NROWS         = 20;
  localparam int NMAIN         = 18;
  localparam int READS_PER_ROW = 6;
  localparam int READ_CYCLES   = 10;
  localparam int CYCLE_LIMIT   = NROWS * (12 + READS_PER_ROW * READ_CYCLES) + 200;

  localparam dbg_isa_pkg::word_t  NOP    = 32'h0000_0013;
  localparam dbg_isa_pkg::word_t  EBK_I  = `DBG_ENC_EBREAK;
  localparam dbg_isa_pkg::word_t  CEBK_I = `DBG_ENC_CEBREAK;
  localparam dbg_isa_pkg::word_t  WFI_I  = `DBG_ENC_WFI;
  localparam dbg_isa_pkg::cause_t C_NON  = `DBG_CAUSE_NONE;
  localparam dbg_isa_pkg::cause_t C_EBK  = `DBG_CAUSE_EBREAK;
  localparam dbg_isa_pkg::cause_t C_TRG  = `DBG_CAUSE_TRIGGER;
  localparam dbg_isa_pkg::cause_t C_HLT  = `DBG_CAUSE_HALTREQ;
  localparam dbg_isa_pkg::cause_t C_STP  = `DBG_CAUSE_STEP;

  logic                      cov_assert_if;
  logic                      rst_n;
  dbg_isa_pkg::retire_t      retire;
  dbg_isa_pkg::core_status_t core;
  dbg_mon_pkg::axil_req_t    axil_req;
  dbg_mon_pkg::axil_rsp_t    axil_rsp;
  logic                      wfi_sleep;
  row_t                      rows [NROWS];
  int                        errors = 0;
  int                        checks = 0;
  int                        cycles = 0;

  // Reference model state
  dbg_isa_pkg::cause_t m_cause;
  dbg_isa_pkg::cause_t m_last;
  dbg_isa_pkg::addr_t  m_pc_dbg;
  dbg_isa_pkg::addr_t  m_pc_eb;
  dbg_mon_pkg::count_t m_entries;
  dbg_mon_pkg::count_t m_cause_err;
  dbg_mon_pkg::count_t m_pc_err;
  logic                m_sleep;
  logic                m_en;

  dbg_event_monitor DUT (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n),
    .retire_i      (retire),
    .core_i        (core),
    .axil_req_i    (axil_req),
    .axil_rsp_o    (axil_rsp),
    .wfi_sleep_o   (wfi_sleep)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #4 cov_assert_if = ~cov_assert_if;
  end

  always @(posedge cov_assert_if) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles: a handshake never completed", cycles);
      $display("Errors found");
      $finish;
    end
  end

  `include "tb_dbg_event_monitor_tasks.svh"

  function automatic dbg_mon_pkg::count_t bump(dbg_mon_pkg::count_t c);
    return (c == '1) ? c : c + 1'b1;
  endfunction

  // pc, next_pc, instr, {err,step,ebreakm,debug_req,trig_en,irq}, tdata2, cause, depc, mode
  task automatic load_table;
    rows[0]  = '{32'h100, 32'h104, NOP,    6'b000010, 32'h100, C_TRG, 32'h100, 2'b10};
    rows[1]  = '{32'h200, 32'h204, EBK_I,  6'b001000, 32'h0,   C_EBK, 32'h200, 2'b10};
    rows[2]  = '{32'h300, 32'h304, NOP,    6'b000100, 32'h0,   C_HLT, 32'h304, 2'b10};
    rows[3]  = '{32'h400, 32'h404, NOP,    6'b010000, 32'h0,   C_STP, 32'h404, 2'b10};
    rows[4]  = '{32'h500, 32'h504, NOP,    6'b000110, 32'h500, C_TRG, 32'h500, 2'b10};
    rows[5]  = '{32'h600, 32'h602, CEBK_I, 6'b011000, 32'h0,   C_EBK, 32'h600, 2'b10};
    // Core reports the wrong cause
    rows[6]  = '{32'h700, 32'h704, NOP,    6'b000100, 32'h0,   C_STP, 32'h704, 2'b10};
    // Core reports the wrong depc
    rows[7]  = '{32'h800, 32'h804, NOP,    6'b010000, 32'h0,   C_STP, 32'h900, 2'b10};
    rows[8]  = '{32'ha00, 32'ha04, NOP,    6'b000010, 32'ha00, C_NON, 32'h0,   2'b00};
    rows[9]  = '{32'hb00, 32'hb04, EBK_I,  6'b000000, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[10] = '{32'hc00, 32'hc04, EBK_I,  6'b101000, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[11] = '{32'hd00, 32'hd04, NOP,    6'b000100, 32'h0,   C_HLT, 32'hd04, 2'b10};
    // wfi sleep and wake-up
    rows[12] = '{32'he00, 32'he04, WFI_I,  6'b000000, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[13] = '{32'he10, 32'he14, NOP,    6'b000001, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[14] = '{32'he20, 32'he24, WFI_I,  6'b000000, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[15] = '{32'he30, 32'he34, NOP,    6'b000100, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[16] = '{32'he40, 32'he44, WFI_I,  6'b010000, 32'h0,   C_NON, 32'h0,   2'b00};
    rows[17] = '{32'he50, 32'he54, NOP,    6'b000000, 32'h0,   C_STP, 32'he54, 2'b11};
    // Control phase rows
    rows[18] = '{32'hf00, 32'hf04, NOP,    6'b000100, 32'h0,   C_HLT, 32'h0,   2'b10};
    rows[19] = '{32'hf10, 32'hf14, NOP,    6'b010000, 32'h0,   C_STP, 32'hf14, 2'b10};
  endtask

  task automatic model_row(input row_t r);
    logic clean;
    logic is_eb;
    logic is_wfi;
    logic trig;
    clean  = !r.flags.err;
    is_eb  = clean && ((r.instr == EBK_I) || (r.instr == CEBK_I));
    is_wfi = clean && (r.instr == WFI_I);
    trig   = r.flags.trig_en && (r.pc == r.tdata2);
    // Priority trigger, ebreak, halt request, step
    if (trig) begin
      m_cause = C_TRG;
    end else if (is_eb && r.flags.ebreakm) begin
      m_cause = C_EBK;
    end else if (r.flags.debug_req) begin
      m_cause = C_HLT;
    end else if (r.flags.step) begin
      m_cause = C_STP;
    end
    m_pc_dbg = (trig || (is_eb && r.flags.ebreakm)) ? r.pc : r.next_pc;
    if (is_eb) begin
      m_pc_eb = r.pc;
    end
    if (m_sleep) begin
      if (r.flags.irq || r.flags.debug_req) begin
        m_sleep = 1'b0;
      end
    end else if (is_wfi && !r.flags.debug_req && !r.flags.step && !r.flags.irq) begin
      m_sleep = 1'b1;
    end
    if (r.mode.entry) begin
      if (m_en) begin
        m_entries = bump(m_entries);
        if (r.dcsr_cause != m_cause) begin
          m_cause_err = bump(m_cause_err);
        end
        if ((m_cause != C_NON) && (r.depc != m_pc_dbg)) begin
          m_pc_err = bump(m_pc_err);
        end
        m_last = r.dcsr_cause;
      end
      m_cause = C_NON;
    end
  endtask

  task automatic check_regs;
    dbg_isa_pkg::word_t d;
    dbg_isa_pkg::word_t status;
    logic [1:0]         resp;
    status = dbg_isa_pkg::word_t'({m_sleep, 1'b0, m_last, 1'b0, m_cause});
    axil_read(`DBG_REG_ENTRIES, d, resp);
    check_resp("ENTRIES rresp", resp, `DBG_RESP_OKAY);
    check_count("ENTRIES", dbg_mon_pkg::count_t'(d), m_entries);
    axil_read(`DBG_REG_CAUSE_ERR, d, resp);
    check_resp("CAUSE_ERR rresp", resp, `DBG_RESP_OKAY);
    check_count("CAUSE_ERR", dbg_mon_pkg::count_t'(d), m_cause_err);
    axil_read(`DBG_REG_PC_ERR, d, resp);
    check_resp("PC_ERR rresp", resp, `DBG_RESP_OKAY);
    check_count("PC_ERR", dbg_mon_pkg::count_t'(d), m_pc_err);
    axil_read(`DBG_REG_STATUS, d, resp);
    check_resp("STATUS rresp", resp, `DBG_RESP_OKAY);
    check_cause("STATUS expected cause", d[2:0], m_cause);
    check_cause("STATUS last cause", d[6:4], m_last);
    check_word("STATUS", d, status);
    axil_read(`DBG_REG_PC_DBG, d, resp);
    check_resp("PC_DBG rresp", resp, `DBG_RESP_OKAY);
    check_word("PC_DBG", d, m_pc_dbg);
    axil_read(`DBG_REG_PC_EBREAK, d, resp);
    check_resp("PC_EBREAK rresp", resp, `DBG_RESP_OKAY);
    check_word("PC_EBREAK", d, m_pc_eb);
    check_word("wfi_sleep_o", dbg_isa_pkg::word_t'(wfi_sleep), dbg_isa_pkg::word_t'(m_sleep));
  endtask

  task automatic run_row(input int idx);
    drive_row(rows[idx]);
    model_row(rows[idx]);
    check_regs();
  endtask

  initial begin
    dbg_isa_pkg::word_t d;
    logic [1:0]         resp;
    void'($urandom(32'h9a22));
    rst_n       = 1'b0;
    retire      = '0;
    core        = '0;
    axil_req    = '0;
    m_cause     = C_NON;
    m_last      = C_NON;
    m_pc_dbg    = '0;
    m_pc_eb     = '0;
    m_entries   = '0;
    m_cause_err = '0;
    m_pc_err    = '0;
    m_sleep     = 1'b0;
    m_en        = 1'b1;
    load_table();
    repeat (8) @(posedge cov_assert_if);
    @(negedge cov_assert_if);
    rst_n = 1'b1;
    check_regs();

    for (int i = 0; i < NMAIN; i++) begin
      run_row(i);
    end

    // ----------------------------------------
    // Control register
    // ----------------------------------------
    axil_write(`DBG_REG_CTRL, 32'h3, resp);
    check_resp("CTRL clear bresp", resp, `DBG_RESP_OKAY);
    m_entries   = '0;
    m_cause_err = '0;
    m_pc_err    = '0;
    check_regs();
    axil_write(`DBG_REG_STATUS, 32'h0, resp);
    check_resp("STATUS write bresp", resp, `DBG_RESP_SLVERR);
    axil_read(5'h1c, d, resp);
    check_resp("unmapped rresp", resp, `DBG_RESP_SLVERR);
    check_word("unmapped rdata", d, '0);
    axil_read(`DBG_REG_CTRL, d, resp);
    check_word("CTRL", d, 32'h1);
    // Entry while disabled is not counted
    axil_write(`DBG_REG_CTRL, 32'h0, resp);
    check_resp("CTRL disable bresp", resp, `DBG_RESP_OKAY);
    m_en = 1'b0;
    axil_read(`DBG_REG_CTRL, d, resp);
    check_word("CTRL", d, 32'h0);
    run_row(18);
    axil_write(`DBG_REG_CTRL, 32'h1, resp);
    check_resp("CTRL enable bresp", resp, `DBG_RESP_OKAY);
    m_en = 1'b1;
    run_row(19);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dbg_event_monitor.f */
+incdir+.
dbg_isa_pkg.sv
dbg_mon_pkg.sv
dbg_instr_decode.sv
dbg_cause_track.sv
dbg_pc_capture.sv
dbg_mon_regs.sv
dbg_event_monitor.sv
tb_dbg_event_monitor.sv
